// ==== source/palette_pkg.sv ====
`default_nettype none

package palette_pkg;

    // Reduced raster, in pixels per line
    localparam int H_TOTAL  = 96;
    localparam int H_ACTIVE = 64;

    // Reduced raster, in lines per frame
    localparam int V_TOTAL  = 40;
    localparam int V_ACTIVE = 32;

    // Strobes between request sample and RGB output
    localparam int PXL_DLY = 3;

    // Pen field sits in the low bits of a request
    localparam int PEN_W = 4;

    // Bank in bits 6..4, pen in bits 3..0
    typedef logic [6:0]  colour_req_t;

    // Palette byte address and data
    typedef logic [7:0]  pal_addr_t;
    typedef logic [7:0]  pal_byte_t;

    // Blue in 14..10, green in 9..5, red in 4..0
    typedef logic [14:0] rgb_t;

    // Raster counters
    typedef logic [6:0]  hcount_t;
    typedef logic [5:0]  vcount_t;

    // Per-pixel layer requests
    typedef struct packed {
        colour_req_t tile;
        colour_req_t obj;
        logic        prio;
    } layer_req_t;

    // CPU access, single-cycle strobe
    typedef struct packed {
        logic      cs;
        logic      we;
        pal_addr_t addr;
        pal_byte_t wdata;
    } cpu_bus_t;

endpackage

`default_nettype wire

// ==== source/video_timing.sv ====
`timescale 1ns/1ns
`default_nettype none

module video_timing import palette_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    output logic    pxl_cen,
    output logic    LHBL,
    output logic    LVBL,
    output hcount_t hcount,
    output vcount_t vcount
);

    logic line_end;
    logic frame_end;

    // Pixel strobe at half the clock rate
    // Low in the first cycle after reset, then alternating
    always_ff @(posedge clk) begin
        if (rst) begin
            pxl_cen <= 1'b0;
        end else begin
            pxl_cen <= ~pxl_cen;
        end
    end

    // Last pixel of the line
    assign line_end  = hcount == hcount_t'(H_TOTAL - 1);

    // Last line of the frame
    assign frame_end = vcount == vcount_t'(V_TOTAL - 1);

    // Raster counters, advanced once per strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
        end else if (pxl_cen) begin
            if (line_end) begin
                hcount <= '0;
                // Line count moves on at the end of each line
                if (frame_end) begin
                    vcount <= '0;
                end else begin
                    vcount <= vcount + 1'b1;
                end
            end else begin
                hcount <= hcount + 1'b1;
            end
        end
    end

    // Blanking, high in the active area
    // Decoded straight from the counter registers
    assign LHBL = hcount < hcount_t'(H_ACTIVE);
    assign LVBL = vcount < vcount_t'(V_ACTIVE);

    // Strobe is one clock wide, with a gap after it
    a_cen_single: assert property (
        @(posedge clk) disable iff (rst)
        pxl_cen |=> !pxl_cen
    );

    // Counters stay inside the raster
    a_count_range: assert property (
        @(posedge clk) disable iff (rst)
        (hcount < hcount_t'(H_TOTAL)) && (vcount < vcount_t'(V_TOTAL))
    );

endmodule

`default_nettype wire

// ==== source/layer_priority.sv ====
`timescale 1ns/1ns
`default_nettype none

module layer_priority import palette_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        pxl_cen,
    input  layer_req_t  req,
    output colour_req_t gfx_pxl
);

    logic        tile_opaque;
    logic        obj_opaque;
    colour_req_t winner;

    // Pen zero means transparent
    assign tile_opaque = req.tile[PEN_W-1:0] != '0;
    assign obj_opaque  = req.obj[PEN_W-1:0]  != '0;

    // Priority mux
    always_comb begin
        // Tile is the fallback in both modes
        winner = req.tile;
        if (req.prio) begin
            // Tile on top, object only shows through clear tile pens
            if (!tile_opaque && obj_opaque) begin
                winner = req.obj;
            end
        end else begin
            // Object on top
            if (obj_opaque) begin
                winner = req.obj;
            end
        end
    end

    // First pipeline stage
    // Request captured at the strobe, held for the pixel period
    always_ff @(posedge clk) begin
        if (rst) begin
            gfx_pxl <= '0;
        end else if (pxl_cen) begin
            gfx_pxl <= winner;
        end
    end

endmodule

`default_nettype wire

// ==== source/palette_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module palette_ram import palette_pkg::*; (
    input  logic      clk,
    input  cpu_bus_t  cpu,
    output pal_byte_t cpu_rdata,
    input  pal_addr_t vid_addr,
    output pal_byte_t vid_data
);

    // 256 bytes, two bytes per colour
    pal_byte_t mem [2**$bits(pal_addr_t)];

    // CPU port, read and write
    // Reads return old data on a write cycle
    always_ff @(posedge clk) begin
        if (cpu.cs) begin
            if (cpu.we) begin
                mem[cpu.addr] <= cpu.wdata;
            end
            cpu_rdata <= mem[cpu.addr];
        end
    end

    // Video port, read only
    // One clock latency, every clock
    always_ff @(posedge clk) begin
        vid_data <= mem[vid_addr];
    end

    // Write strobe only valid with chip select
    a_we_needs_cs: assert property (
        @(posedge clk)
        cpu.we |-> cpu.cs
    );

endmodule

`default_nettype wire

// ==== source/colour_mixer.sv ====
`timescale 1ns/1ns
`default_nettype none

module colour_mixer import palette_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        pxl_cen,
    input  colour_req_t gfx_pxl,
    output pal_addr_t   vid_addr,
    input  pal_byte_t   vid_data,
    output rgb_t        colour
);

    // Selects the high byte when set
    logic half;

    // Last two bytes from the video port
    logic [2*$bits(pal_byte_t)-1:0] byte_sr;

    // Half-select
    // Set at the strobe, so high byte goes out first
    // Then low byte in the second clock of the pixel
    always_ff @(posedge clk) begin
        if (rst) begin
            half <= 1'b0;
        end else if (pxl_cen) begin
            half <= 1'b1;
        end else begin
            half <= ~half;
        end
    end

    // Byte address is the colour index plus the half bit
    assign vid_addr = {gfx_pxl, half};

    // Collect returned bytes
    // High byte arrives first, low byte lands in the bottom
    always_ff @(posedge clk) begin
        byte_sr <= {byte_sr[$bits(pal_byte_t)-1:0], vid_data};
    end

    // Colour latch
    // At the strobe the register holds {high, low} of the last pixel
    // Bit 7 of the high byte is dropped
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            colour <= byte_sr[$bits(rgb_t)-1:0];
        end
    end

    // High byte address leads every pixel period
    a_half_after_cen: assert property (
        @(posedge clk) disable iff (rst)
        pxl_cen |=> half
    );

    // Low byte address follows in the second clock
    a_half_low: assert property (
        @(posedge clk) disable iff (rst)
        pxl_cen ##1 1'b1 |=> !half
    );

    // Request stays put while both bytes are read
    a_req_stable: assert property (
        @(posedge clk) disable iff (rst)
        !pxl_cen |=> $stable(gfx_pxl)
    );

endmodule

`default_nettype wire

// ==== source/blank_delay.sv ====
`timescale 1ns/1ns
`default_nettype none

module blank_delay import palette_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       pxl_cen,
    input  logic       LHBL,
    input  logic       LVBL,
    input  rgb_t       colour,
    output logic       LHBL_dly,
    output logic       LVBL_dly,
    output logic [4:0] red,
    output logic [4:0] green,
    output logic [4:0] blue
);

    // Blanking delay lines, top bit feeds the output register
    logic [PXL_DLY-1:0] lhbl_sr;
    logic [PXL_DLY-1:0] lvbl_sr;

    // Active area for the colour now at the input
    logic active;

    // Output colour register
    rgb_t rgb_q;

    // Blanking of the pixel whose colour is arriving
    assign active = lhbl_sr[PXL_DLY-1] & lvbl_sr[PXL_DLY-1];

    // Blanking and colour move together on the strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            lhbl_sr  <= '0;
            lvbl_sr  <= '0;
            rgb_q    <= '0;
            LHBL_dly <= 1'b0;
            LVBL_dly <= 1'b0;
        end else if (pxl_cen) begin
            lhbl_sr  <= {lhbl_sr[PXL_DLY-2:0], LHBL};
            lvbl_sr  <= {lvbl_sr[PXL_DLY-2:0], LVBL};
            // Blanking leaves with its own colour
            LHBL_dly <= lhbl_sr[PXL_DLY-1];
            LVBL_dly <= lvbl_sr[PXL_DLY-1];
            // Black outside the active area
            rgb_q    <= active ? colour : '0;
        end
    end

    // Channel split, blue on top
    assign {blue, green, red} = rgb_q;

endmodule

`default_nettype wire

// ==== source/video_colour.sv ====
`timescale 1ns/1ns
`default_nettype none

module video_colour import palette_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  layer_req_t req,
    input  cpu_bus_t   cpu,
    output pal_byte_t  pal_rdata,
    output logic       pxl_cen,
    output logic       LHBL,
    output logic       LVBL,
    output logic       LHBL_dly,
    output logic       LVBL_dly,
    output logic [4:0] red,
    output logic [4:0] green,
    output logic [4:0] blue
);

    // Winning layer request
    colour_req_t gfx_pxl;

    // Video side of the palette
    pal_addr_t   vid_addr;
    pal_byte_t   vid_data;

    // Colour before blanking
    rgb_t        colour;

    // Strobe and raster, counters stay inside
    video_timing i_video_timing (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .LHBL    (LHBL),
        .LVBL    (LVBL),
        .hcount  (),
        .vcount  ()
    );

    // Tile or object by pen and mode
    layer_priority i_layer_priority (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .req     (req),
        .gfx_pxl (gfx_pxl)
    );

    // CPU and video share the palette
    palette_ram i_palette_ram (
        .clk       (clk),
        .cpu       (cpu),
        .cpu_rdata (pal_rdata),
        .vid_addr  (vid_addr),
        .vid_data  (vid_data)
    );

    // Two byte reads per pixel
    colour_mixer i_colour_mixer (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .gfx_pxl  (gfx_pxl),
        .vid_addr (vid_addr),
        .vid_data (vid_data),
        .colour   (colour)
    );

    // Blanking aligned to the colour pipeline
    blank_delay i_blank_delay (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .LHBL     (LHBL),
        .LVBL     (LVBL),
        .colour   (colour),
        .LHBL_dly (LHBL_dly),
        .LVBL_dly (LVBL_dly),
        .red      (red),
        .green    (green),
        .blue     (blue)
    );

endmodule

`default_nettype wire

// ==== test/video_colour_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module video_colour_tb import palette_pkg::*; ();

    localparam int CLK_PERIOD    = 100;
    localparam int PAL_SIZE      = 256;
    localparam int VIDEO_STROBES = 2 * H_TOTAL * V_TOTAL;
    // Two clocks per strobe, plus palette load and readback, plus slack
    localparam int WATCHDOG_NS   = (VIDEO_STROBES * 2 + 3 * PAL_SIZE + 500) * CLK_PERIOD;
    // Strobes of the video run that carry a palette write
    localparam int WRITE_AT_0    = 1500;
    localparam int WRITE_AT_1    = 5000;

    logic       clk;
    logic       rst;
    layer_req_t req;
    cpu_bus_t   cpu;
    pal_byte_t  pal_rdata;
    logic       pxl_cen;
    logic       LHBL;
    logic       LVBL;
    logic       LHBL_dly;
    logic       LVBL_dly;
    logic [4:0] red;
    logic [4:0] green;
    logic [4:0] blue;

    // Stimulus row and the index the priority rule picks
    typedef struct packed {
        layer_req_t  req;
        colour_req_t win;
    } vec_t;

    vec_t        vecs[$];
    pal_byte_t   pal_model [PAL_SIZE];
    logic [31:0] lfsr;
    int          clk_cnt;
    int          checks;
    int          errors;

    // Expected colour and blanking, oldest first
    rgb_t        col_q[$];
    logic [1:0]  blank_q[$];

    video_colour i_video_colour (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .cpu       (cpu),
        .pal_rdata (pal_rdata),
        .pxl_cen   (pxl_cen),
        .LHBL      (LHBL),
        .LVBL      (LVBL),
        .LHBL_dly  (LHBL_dly),
        .LVBL_dly  (LVBL_dly),
        .red       (red),
        .green     (green),
        .blue      (blue)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Clocks since reset, strobe on every second one
    // Raster position follows from it
    always @(posedge clk) begin
        if (rst) begin
            clk_cnt <= 0;
        end else begin
            clk_cnt <= clk_cnt + 1;
        end
    end

    // Galois form, right shift
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit
    function automatic pal_byte_t random_byte();
        pal_byte_t b;
        b = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_next(lfsr);
            b    = {b[6:0], lfsr[0]};
        end
        return b;
    endfunction

    // Low byte at {c,0}, high byte at {c,1} with bit 7 unused
    function automatic rgb_t model_colour(input colour_req_t c);
        return {pal_model[{c, 1'b1}][6:0], pal_model[{c, 1'b0}]};
    endfunction

    task automatic colour_check(input rgb_t got, input rgb_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t {blue,green,red} got %h exp %h", $time, got, exp);
        end
    endtask

    task automatic byte_check(input string name, input pal_byte_t got, input pal_byte_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic flag_check(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %b exp %b", $time, name, got, exp);
        end
    endtask

    task automatic add_vec(input colour_req_t tile, input colour_req_t obj,
                           input logic prio, input colour_req_t win);
        vec_t v;
        v.req.tile = tile;
        v.req.obj  = obj;
        v.req.prio = prio;
        v.win      = win;
        vecs.push_back(v);
    endtask

    // Eleven rows, coprime with the line length
    task automatic load_table();
        // Object on top
        add_vec(7'h12, 7'h35, 1'b0, 7'h35);
        add_vec(7'h12, 7'h30, 1'b0, 7'h12);
        add_vec(7'h7f, 7'h01, 1'b0, 7'h01);
        add_vec(7'h0e, 7'h3a, 1'b0, 7'h3a);
        // Tile on top
        add_vec(7'h21, 7'h4f, 1'b1, 7'h21);
        add_vec(7'h20, 7'h4f, 1'b1, 7'h4f);
        add_vec(7'h03, 7'h7e, 1'b1, 7'h03);
        add_vec(7'h2b, 7'h00, 1'b1, 7'h2b);
        // Both pens clear, tile index used
        add_vec(7'h60, 7'h10, 1'b1, 7'h60);
        add_vec(7'h50, 7'h70, 1'b0, 7'h50);
        add_vec(7'h00, 7'h00, 1'b0, 7'h00);
    endtask

    task automatic drive_write(input pal_addr_t a, input pal_byte_t d);
        cpu.cs    = 1'b1;
        cpu.we    = 1'b1;
        cpu.addr  = a;
        cpu.wdata = d;
    endtask

    task automatic write_byte(input pal_addr_t a, input pal_byte_t d);
        drive_write(a, d);
        @(negedge clk);
        cpu = '0;
    endtask

    // Data is due one clock after the read cycle
    task automatic read_and_compare(input pal_addr_t a);
        cpu.cs    = 1'b1;
        cpu.we    = 1'b0;
        cpu.addr  = a;
        cpu.wdata = '0;
        @(negedge clk);
        cpu = '0;
        byte_check("pal_rdata", pal_rdata, pal_model[a]);
    endtask

    task automatic load_palette();
        pal_addr_t a;
        for (int i = 0; i < PAL_SIZE; i++) begin
            a            = pal_addr_t'(i);
            pal_model[a] = random_byte();
            write_byte(a, pal_model[a]);
        end
    endtask

    // Odd stride visits every address once, out of order
    task automatic readback_palette();
        for (int i = 0; i < PAL_SIZE; i++) begin
            read_and_compare(pal_addr_t'(i * 37));
        end
    endtask

    // Falling edge just before a strobe edge
    // Strobe due on every odd clock since reset
    task automatic wait_strobe();
        @(negedge clk);
        flag_check("pxl_cen", pxl_cen, clk_cnt[0]);
        while (!clk_cnt[0]) begin
            @(negedge clk);
            flag_check("pxl_cen", pxl_cen, clk_cnt[0]);
        end
    endtask

    // Outputs now hold the result of the previous strobe
    task automatic output_check();
        logic [1:0] bl;
        rgb_t       col;
        if (blank_q.size() == PXL_DLY + 1) begin
            bl  = blank_q.pop_front();
            col = col_q.pop_front();
            flag_check("LHBL_dly", LHBL_dly, bl[1]);
            flag_check("LVBL_dly", LVBL_dly, bl[0]);
            // Black whenever either delayed blanking is low
            colour_check({blue, green, red}, (bl[1] && bl[0]) ? col : '0);
        end
    endtask

    task automatic run_video();
        int          h;
        int          v;
        logic        exp_lhbl;
        logic        exp_lvbl;
        logic        mid_write;
        vec_t        vec;
        colour_req_t wr_idx;
        for (int k = 0; k < VIDEO_STROBES; k++) begin
            wait_strobe();
            cpu = '0;
            output_check();
            // Raster position about to be sampled
            h        = (clk_cnt / 2) % H_TOTAL;
            v        = ((clk_cnt / 2) / H_TOTAL) % V_TOTAL;
            exp_lhbl = h < H_ACTIVE;
            exp_lvbl = v < V_ACTIVE;
            flag_check("LHBL", LHBL, exp_lhbl);
            flag_check("LVBL", LVBL, exp_lvbl);
            blank_q.push_back({exp_lhbl, exp_lvbl});
            vec       = vecs[k % vecs.size()];
            mid_write = (k == WRITE_AT_0) || (k == WRITE_AT_1);
            // New colour for the index this pixel uses
            // High byte lands at this strobe, low byte one clock later
            if (mid_write) begin
                wr_idx                   = vec.win;
                pal_model[{wr_idx, 1'b1}] = random_byte();
                pal_model[{wr_idx, 1'b0}] = random_byte();
                drive_write({wr_idx, 1'b1}, pal_model[{wr_idx, 1'b1}]);
            end
            req = vec.req;
            col_q.push_back(model_colour(vec.win));
            if (mid_write) begin
                @(negedge clk);
                drive_write({wr_idx, 1'b0}, pal_model[{wr_idx, 1'b0}]);
            end
        end
    endtask

    initial begin
        rst    = 1'b1;
        req    = '0;
        cpu    = '0;
        lfsr   = 32'h32e2;
        checks = 0;
        errors = 0;
        load_table();
        repeat (3) @(negedge clk);
        // Still in reset here
        flag_check("pxl_cen", pxl_cen, 1'b0);
        flag_check("LHBL_dly", LHBL_dly, 1'b0);
        flag_check("LVBL_dly", LVBL_dly, 1'b0);
        colour_check({blue, green, red}, '0);
        rst = 1'b0;
        load_palette();
        readback_palette();
        run_video();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns, the video run did not finish", WATCHDOG_NS);
        $display("checks %0d, errors %0d", checks, errors);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// ==== video_colour.f ====
source/palette_pkg.sv
source/video_timing.sv
source/layer_priority.sv
source/palette_ram.sv
source/colour_mixer.sv
source/blank_delay.sv
source/video_colour.sv
test/video_colour_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module video_colour_tb -f video_colour.f
	@out="$$(./obj_dir/Vvideo_colour_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '=== PASS ==='

clean:
	rm -rf obj_dir
